// ==== design/addr_acq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_acq_fsm (
  input  logic                      tx_clock,
  input  logic                      arst_n,
  input  logic                      delay_start,
  input  logic                      phy_connected,
  input  netcfg_pkg::dhcp_result_t  dhcp_result,
  input  netcfg_pkg::timer_stat_t   timer_stat,
  input  logic                      static_valid,
  output netcfg_pkg::timer_ctl_t    timer_ctl,
  output netcfg_pkg::addr_cmd_t     addr_cmd,
  output logic                      network_state_dhcp,
  output logic                      network_state_fixedip,
  output logic                      dhcp_tx_enable,
  output logic                      dhcp_rx_enable
);
  import netcfg_pkg::*;

  acq_state_e         state;
  acq_state_e         next_state;
  logic [RENEW_W-1:0] renew_load;    // half lease in seconds
  logic               link_lost;

  assign renew_load = (dhcp_result.lease == '0) ? DEFAULT_RENEW_SECONDS
                                                : dhcp_result.lease[RENEW_W:1];

  // link drop counts once past wait_link
  assign link_lost = !phy_connected && (state != wait_start) && (state != wait_link);

  // --------------------------------------------------------------------------
  // next state, timer and address commands
  // --------------------------------------------------------------------------
  always_comb begin
    next_state           = state;
    addr_cmd             = '0;
    timer_ctl.restart    = 1'b0;
    timer_ctl.load       = 1'b0;
    timer_ctl.load_value = '0;

    case (state)                     // countdown mode follows the state
      settle, dhcp_retry:    timer_ctl.mode = per_cycle;
      renew_wait, renew_ack: timer_ctl.mode = per_second;
      default:               timer_ctl.mode = hold;
    endcase

    if (link_lost) begin
      next_state = wait_link;
    end else begin
      case (state)
        wait_start: begin
          if (!delay_start) next_state = wait_link;
        end
        wait_link: begin
          if (phy_connected) begin
            timer_ctl.load       = 1'b1;
            timer_ctl.load_value = SETTLE_CYCLES;
            next_state           = settle;
          end
        end
        settle: begin
          if (timer_stat.count_zero && static_valid) begin
            addr_cmd.load_static = 1'b1;
            next_state           = running;
          end else if (timer_stat.count_zero) begin
            addr_cmd.clear    = 1'b1;
            timer_ctl.restart = 1'b1;     // second 0 of discovery
            next_state        = dhcp_request;
          end
        end
        dhcp_request: next_state = dhcp_wait;
        dhcp_wait: begin
          if (dhcp_result.success) begin
            addr_cmd.load_dhcp   = 1'b1;
            timer_ctl.restart    = 1'b1;  // align ticks to the lease
            timer_ctl.load       = 1'b1;
            timer_ctl.load_value = renew_load;
            next_state           = renew_wait;
          end else if (timer_stat.second_tick) begin
            // old seconds value, so 0/2/6 means 1/3/7 s
            if ((timer_stat.seconds == 4'd0) || (timer_stat.seconds == 4'd2) ||
                (timer_stat.seconds == 4'd6)) begin
              timer_ctl.load       = 1'b1;
              timer_ctl.load_value = RETRY_GAP_CYCLES;
              next_state           = dhcp_retry;
            end else if (timer_stat.seconds == 4'(APIPA_SECONDS - 1)) begin
              addr_cmd.load_apipa = 1'b1;  // no offer, go link-local
              next_state          = running;
            end
          end
        end
        dhcp_retry: begin
          if (timer_stat.count_zero) next_state = dhcp_request;
        end
        renew_wait: begin
          if (timer_stat.count_zero) next_state = renew_req;
        end
        renew_req: begin
          timer_ctl.restart    = 1'b1;
          timer_ctl.load       = 1'b1;
          timer_ctl.load_value = RENEW_ACK_SECONDS;  // wait for ack
          next_state           = renew_ack;
        end
        renew_ack: begin
          if (dhcp_result.success) begin
            timer_ctl.restart    = 1'b1;
            timer_ctl.load       = 1'b1;
            timer_ctl.load_value = renew_load;
            next_state           = renew_wait;
          end else if (timer_stat.count_zero) begin
            timer_ctl.load       = 1'b1;
            timer_ctl.load_value = RENEW_RETRY_SECONDS;  // try again later
            next_state           = renew_wait;
          end
        end
        default: next_state = state;  // running stays put
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // state and registered outputs
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state                 <= wait_start;
      network_state_dhcp    <= 1'b1;
      network_state_fixedip <= 1'b1;
      dhcp_tx_enable        <= 1'b0;
      dhcp_rx_enable        <= 1'b0;
    end else begin
      state <= next_state;
      // discover or renew request, one pulse on entry
      dhcp_tx_enable <= (next_state != state) &&
                        ((next_state == dhcp_wait) || (next_state == renew_ack));

      if (link_lost) begin
        network_state_dhcp    <= 1'b1;
        network_state_fixedip <= 1'b1;
        dhcp_rx_enable        <= 1'b0;
      end else begin
        if ((next_state == dhcp_request) || (next_state == renew_req)) begin
          dhcp_rx_enable <= 1'b1;
        end else if ((next_state == running) || (next_state == renew_wait) ||
                     (next_state == dhcp_retry)) begin
          dhcp_rx_enable <= 1'b0;
        end
        if ((state == dhcp_wait) && (next_state == renew_wait)) begin
          network_state_dhcp <= 1'b0;     // lease held
        end
        if (next_state == running) begin
          network_state_fixedip <= 1'b0;  // static or link-local
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/lease_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_timer (
  input  logic                     tx_clock,
  input  logic                     arst_n,
  input  netcfg_pkg::timer_ctl_t   timer_ctl,
  output netcfg_pkg::timer_stat_t  timer_stat
);
  import netcfg_pkg::*;

  logic [TICK_W-1:0]  tick_cnt;      // cycles within current second
  logic [3:0]         seconds;
  logic [RENEW_W-1:0] countdown;
  logic               tick;

  assign tick = (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1));

  // --------------------------------------------------------------------------
  // one-second divider and elapsed seconds
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
      seconds  <= '0;
    end else if (timer_ctl.restart) begin
      tick_cnt <= '0;                // first tick a full second later
      seconds  <= '0;
    end else begin
      if (tick) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      if (tick && (seconds != 4'hf)) begin
        seconds <= seconds + 4'd1;   // hold at 15
      end
    end
  end

  // --------------------------------------------------------------------------
  // countdown, stops at zero
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      countdown <= '0;
    end else if (timer_ctl.load) begin
      countdown <= timer_ctl.load_value;
    end else if (countdown != '0) begin
      case (timer_ctl.mode)
        per_cycle:  countdown <= countdown - 1'b1;
        per_second: begin
          if (tick) begin
            countdown <= countdown - 1'b1;
          end
        end
        default:    countdown <= countdown;    // hold
      endcase
    end
  end

  assign timer_stat.second_tick = tick;
  assign timer_stat.seconds     = seconds;
  assign timer_stat.count_zero  = (countdown == '0);

endmodule

`default_nettype wire

// ==== design/local_addr_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module local_addr_reg (
  input  logic                   tx_clock,
  input  logic                   arst_n,
  input  netcfg_pkg::addr_cmd_t  addr_cmd,
  input  logic [31:0]            static_ip,
  input  logic [31:0]            ip_accept,
  input  logic [47:0]            local_mac,
  output logic [31:0]            local_ip,
  output logic                   static_valid
);

  logic [31:0] apipa_ip;

  // all-zero or all-one means no static address configured
  assign static_valid = (static_ip != 32'h0000_0000) && (static_ip != 32'hffff_ffff);

  // link-local 169.254.x.y, low half from the mac
  assign apipa_ip = {8'd169, 8'd254, local_mac[15:0]};

  // --------------------------------------------------------------------------
  // address register, one command per cycle from the fsm
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      local_ip <= '0;
    end else if (addr_cmd.clear) begin
      local_ip <= '0;                // dhcp wants 0.0.0.0
    end else if (addr_cmd.load_static) begin
      local_ip <= static_ip;
    end else if (addr_cmd.load_dhcp) begin
      local_ip <= ip_accept;         // server offer
    end else if (addr_cmd.load_apipa) begin
      local_ip <= apipa_ip;          // fallback after timeout
    end
  end

endmodule

`default_nettype wire

// ==== design/netcfg_pkg.sv ====
`default_nettype none

package netcfg_pkg;

  // --------------------------------------------------------------------------
  // timing constants, shortened for simulation
  // --------------------------------------------------------------------------
  localparam int TICKS_PER_SECOND = 20;                 // 2_500_000 on hardware
  localparam int TICK_W           = $clog2(TICKS_PER_SECOND);
  localparam int RENEW_W          = 18;                 // countdown width

  localparam logic [RENEW_W-1:0] SETTLE_CYCLES    = RENEW_W'(40);   // link settle
  localparam logic [RENEW_W-1:0] RETRY_GAP_CYCLES = RENEW_W'(8);    // gap before rediscover

  localparam int APIPA_SECONDS = 15;                    // give up on dhcp here
  localparam logic [RENEW_W-1:0] RENEW_ACK_SECONDS     = RENEW_W'(20);
  localparam logic [RENEW_W-1:0] RENEW_RETRY_SECONDS   = RENEW_W'(300);
  localparam logic [RENEW_W-1:0] DEFAULT_RENEW_SECONDS = RENEW_W'(43_200); // zero lease

  // --------------------------------------------------------------------------
  // enums
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    wait_start, wait_link, settle, dhcp_request, dhcp_wait,
    dhcp_retry, running, renew_wait, renew_req, renew_ack
  } acq_state_e;

  typedef enum logic [1:0] {arp, icmp, dhcp, udp} tx_proto_e;  // priority order

  typedef enum logic [1:0] {hold, per_cycle, per_second} count_mode_e;

  // --------------------------------------------------------------------------
  // bundles between blocks
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic               restart;     // restart divider, clear seconds
    logic               load;        // load countdown, beats counting
    logic [RENEW_W-1:0] load_value;
    count_mode_e        mode;
  } timer_ctl_t;                     // 22 bits

  typedef struct packed {
    logic       second_tick;         // one-cycle pulse
    logic [3:0] seconds;             // since last restart, saturates
    logic       count_zero;
  } timer_stat_t;                    // 6 bits

  typedef struct packed {
    logic        success;
    logic [31:0] ip_accept;          // offered address
    logic [31:0] lease;              // seconds
  } dhcp_result_t;                   // 65 bits

  typedef struct packed {
    logic load_static;
    logic clear;                     // 0.0.0.0 while dhcp runs
    logic load_dhcp;
    logic load_apipa;
  } addr_cmd_t;

  typedef struct packed {
    logic arp;
    logic icmp;
    logic dhcp;
    logic udp;
  } tx_req_t;                        // request levels

endpackage

`default_nettype wire

// ==== design/netcfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module netcfg_top (
  input  logic                      tx_clock,
  input  logic                      arst_n,
  input  logic                      delay_start,
  input  logic                      phy_connected,
  input  logic [31:0]               static_ip,
  input  logic [47:0]               local_mac,
  input  netcfg_pkg::dhcp_result_t  dhcp_result,
  input  netcfg_pkg::tx_req_t       tx_req,
  input  logic                      phy_tx_active,
  output logic [31:0]               local_ip,
  output logic                      network_state_dhcp,
  output logic                      network_state_fixedip,
  output logic                      dhcp_tx_enable,
  output logic                      dhcp_rx_enable,
  output logic                      tx_start,
  output netcfg_pkg::tx_proto_e     tx_protocol,
  output logic                      udp_tx_enable
);
  import netcfg_pkg::*;

  timer_ctl_t  timer_ctl;
  timer_stat_t timer_stat;
  addr_cmd_t   addr_cmd;
  logic        static_valid;

  // --------------------------------------------------------------------------
  // address acquisition
  // --------------------------------------------------------------------------
  addr_acq_fsm u_fsm (
    .tx_clock              (tx_clock),
    .arst_n                (arst_n),
    .delay_start           (delay_start),
    .phy_connected         (phy_connected),
    .dhcp_result           (dhcp_result),
    .timer_stat            (timer_stat),
    .static_valid          (static_valid),
    .timer_ctl             (timer_ctl),
    .addr_cmd              (addr_cmd),
    .network_state_dhcp    (network_state_dhcp),
    .network_state_fixedip (network_state_fixedip),
    .dhcp_tx_enable        (dhcp_tx_enable),
    .dhcp_rx_enable        (dhcp_rx_enable)
  );

  lease_timer u_timer (
    .tx_clock   (tx_clock),
    .arst_n     (arst_n),
    .timer_ctl  (timer_ctl),
    .timer_stat (timer_stat)
  );

  local_addr_reg u_addr (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .addr_cmd     (addr_cmd),
    .static_ip    (static_ip),
    .ip_accept    (dhcp_result.ip_accept),   // offered address
    .local_mac    (local_mac),
    .local_ip     (local_ip),
    .static_valid (static_valid)
  );

  // --------------------------------------------------------------------------
  // transmit arbitration
  // --------------------------------------------------------------------------
  tx_arbiter u_arb (
    .tx_clock      (tx_clock),
    .arst_n        (arst_n),
    .tx_req        (tx_req),
    .phy_tx_active (phy_tx_active),
    .tx_start      (tx_start),
    .tx_protocol   (tx_protocol),
    .udp_tx_enable (udp_tx_enable)
  );

endmodule

`default_nettype wire

// ==== design/tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
  input  logic                   tx_clock,
  input  logic                   arst_n,
  input  netcfg_pkg::tx_req_t    tx_req,
  input  logic                   phy_tx_active,
  output logic                   tx_start,
  output netcfg_pkg::tx_proto_e  tx_protocol,
  output logic                   udp_tx_enable
);
  import netcfg_pkg::*;

  logic      tx_ready;               // grant latched, start follows
  logic      req_any;
  tx_proto_e req_proto;

  // --------------------------------------------------------------------------
  // fixed priority: arp, icmp, dhcp, udp
  // --------------------------------------------------------------------------
  always_comb begin
    req_any   = 1'b1;
    req_proto = arp;
    if (tx_req.arp) begin
      req_proto = arp;
    end else if (tx_req.icmp) begin
      req_proto = icmp;
    end else if (tx_req.dhcp) begin
      req_proto = dhcp;
    end else begin
      req_proto = udp;
      req_any   = tx_req.udp;        // nothing pending when low
    end
  end

  // --------------------------------------------------------------------------
  // ready/start staging
  // --------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_ready    <= 1'b0;
      tx_start    <= 1'b0;
      tx_protocol <= arp;
    end else if (phy_tx_active) begin
      tx_ready <= 1'b0;              // frame on the wire, release
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;              // one cycle after the grant
    end else if (req_any) begin
      tx_protocol <= req_proto;
      tx_ready    <= 1'b1;
    end
  end

  // dhcp shares the udp sender
  assign udp_tx_enable = tx_start && ((tx_protocol == dhcp) || (tx_protocol == udp));

endmodule

`default_nettype wire

// ==== netcfg.f ====
design/netcfg_pkg.sv
design/lease_timer.sv
design/local_addr_reg.sv
design/tx_arbiter.sv
design/addr_acq_fsm.sv
design/netcfg_top.sv
verif/netcfg_assertions.sv
verif/netcfg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the netcfg testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f netcfg.f \
  --top-module netcfg_tb -o netcfg_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/netcfg_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== verif/netcfg_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module netcfg_assertions (
  input logic                  tx_clock,
  input logic                  arst_n,
  input logic                  dhcp_tx_enable,
  input logic                  tx_ready,
  input logic                  tx_start,
  input netcfg_pkg::tx_proto_e tx_protocol
);

  // discover and renew requests are single pulses
  no_double_pulse: assert property (@(posedge tx_clock) disable iff (!arst_n)
    dhcp_tx_enable |=> !dhcp_tx_enable) else $error("dhcp_tx_enable high two cycles");

  start_after_ready: assert property (@(posedge tx_clock) disable iff (!arst_n)
    $rose(tx_start) |-> $past(tx_ready)) else $error("tx_start without ready");

  // grant frozen while the frame is pending
  proto_stable: assert property (@(posedge tx_clock) disable iff (!arst_n)
    tx_start |=> (!tx_start || $stable(tx_protocol))) else $error("tx_protocol moved");

endmodule

bind addr_acq_fsm netcfg_assertions fsm_sva (
  .tx_clock(tx_clock), .arst_n(arst_n), .dhcp_tx_enable(dhcp_tx_enable),
  .tx_ready(1'b0), .tx_start(1'b0), .tx_protocol(netcfg_pkg::arp)
);

bind tx_arbiter netcfg_assertions arb_sva (
  .tx_clock(tx_clock), .arst_n(arst_n), .dhcp_tx_enable(1'b0),
  .tx_ready(tx_ready), .tx_start(tx_start), .tx_protocol(tx_protocol)
);

`default_nettype wire

// ==== verif/netcfg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module netcfg_tb;
  import netcfg_pkg::*;

  // --------------------------------------------------------------------------
  // run length of each scenario
  // --------------------------------------------------------------------------
  localparam int ARB_ROUNDS      = 40;
  localparam int STATIC_CYCLES   = 3 * 60;
  localparam int FALLBACK_CYCLES = 16 * TICKS_PER_SECOND;
  localparam int SUCCESS_CYCLES  = 60 + 332 * TICKS_PER_SECOND;
  localparam int LINKLOSS_CYCLES = 5 * 360;
  localparam int ARB_CYCLES      = ARB_ROUNDS * 12;
  localparam int CYCLE_LIMIT     = (STATIC_CYCLES + FALLBACK_CYCLES + SUCCESS_CYCLES +
                                    LINKLOSS_CYCLES + ARB_CYCLES) * 12 / 10;

  localparam int DISCOVER_SECONDS [3] = '{1, 3, 7};  // retries after the first discover

  logic         tx_clock = 1'b0;
  logic         arst_n, delay_start, phy_connected, phy_tx_active;
  logic [31:0]  static_ip, local_ip;
  logic [47:0]  local_mac;
  dhcp_result_t dhcp_result;
  tx_req_t      tx_req;
  logic         network_state_dhcp, network_state_fixedip;
  logic         dhcp_tx_enable, dhcp_rx_enable, tx_start, udp_tx_enable;
  tx_proto_e    tx_protocol;

  int cycles = 0;
  int err_ip = 0, err_state = 0, err_proto = 0, err_timing = 0;

  netcfg_top uut (.*);

  always #50 tx_clock = ~tx_clock;   // 100 ns period

  always @(posedge tx_clock) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_ip(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_ip++;
      $display("Error %0t: %s local_ip %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input logic a, input logic b, input logic ea, input logic eb,
                             input string what);
    if ((a !== ea) || (b !== eb)) begin
      err_state++;
      $display("Error %0t: %s flags %b%b, expected %b%b", $time, what, a, b, ea, eb);
    end
  endtask

  task automatic check_proto(input tx_proto_e got, input tx_proto_e exp);
    if (got !== exp) begin
      err_proto++;
      $display("Error %0t: tx_protocol %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_window(input int got, input int exp, input int tol, input string what);
    if ((got < exp - tol) || (got > exp + tol)) begin
      err_timing++;
      $display("Error %0t: %s after %0d cycles, expected %0d +-%0d", $time, what, got,
               exp, tol);
    end
  endtask

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic tx_proto_e grant_model(input logic [3:0] req);
    if (req[3]) return arp;          // arp outranks all
    else if (req[2]) return icmp;
    else if (req[1]) return dhcp;
    else return udp;
  endfunction

  task automatic wait_pulse(input int max_cycles, output int waited, output bit seen);
    waited = 0;
    seen   = 1'b0;
    while (!seen && (waited < max_cycles)) begin
      @(negedge tx_clock);
      waited++;
      seen = dhcp_tx_enable;
    end
  endtask

  task automatic expect_pulse(input int max_cycles, input string what);
    int  waited;
    bit  seen;
    wait_pulse(max_cycles, waited, seen);
    if (!seen) begin
      err_timing++;
      $display("no %s pulse seen within %0d cycles", what, max_cycles);
    end
  endtask

  task automatic start_run(input logic [31:0] sip);
    @(posedge tx_clock);
    arst_n        <= 1'b0;
    phy_connected <= 1'b0;
    static_ip     <= sip;
    dhcp_result   <= '0;
    repeat (2) @(posedge tx_clock);
    arst_n <= 1'b1;
    repeat (3) @(posedge tx_clock);
    phy_connected <= 1'b1;           // link comes up
  endtask

  // --------------------------------------------------------------------------
  // scenarios
  // --------------------------------------------------------------------------
  initial begin
    int          waited, t0, lease_half, hold;
    bit          seen;
    logic [31:0] sip, ip, lease;
    logic [3:0]  req;
    tx_proto_e   exp_proto;
    logic        exp_udp;

    void'($urandom(32'hfb88_8d7c));
    arst_n        = 1'b0;
    delay_start   = 1'b0;
    phy_connected = 1'b0;
    phy_tx_active = 1'b0;
    static_ip     = '0;
    dhcp_result   = '0;
    tx_req        = '0;
    local_mac     = {16'($urandom), $urandom};

    // valid static address
    do sip = $urandom; while ((sip == '0) || (sip == '1));
    start_run(sip);
    waited = 0;
    while (network_state_fixedip && (waited < int'(SETTLE_CYCLES) + 8)) begin
      @(negedge tx_clock);
      waited++;
    end
    check_window(waited, int'(SETTLE_CYCLES), 4, "static address");
    check_ip(local_ip, sip, "static");

    // all-one then all-zero must fall to dhcp
    for (int i = 0; i < 2; i++) begin
      start_run((i == 0) ? 32'hffff_ffff : 32'h0);
      expect_pulse(int'(SETTLE_CYCLES) + 8, "first discover");
      check_state(network_state_dhcp, network_state_fixedip, 1'b1, 1'b1, "invalid static");
    end

    // discover retries at 1, 3 and 7 s then link-local at 15 s
    t0 = cycles;
    for (int k = 0; k < 3; k++) begin
      expect_pulse(8 * TICKS_PER_SECOND, "discover retry");
      check_window(cycles - t0, DISCOVER_SECONDS[k] * TICKS_PER_SECOND, TICKS_PER_SECOND,
                   "retry");
    end
    while (network_state_fixedip && (cycles - t0 < 17 * TICKS_PER_SECOND)) begin
      @(negedge tx_clock);
    end
    check_window(cycles - t0, APIPA_SECONDS * TICKS_PER_SECOND, TICKS_PER_SECOND, "apipa");
    check_ip(local_ip, {8'd169, 8'd254, local_mac[15:0]}, "link-local");
    check_state(network_state_dhcp, network_state_fixedip, 1'b1, 1'b0, "link-local");

    // dhcp success then renew and an unanswered renew
    start_run(32'h0);
    expect_pulse(int'(SETTLE_CYCLES) + 8, "first discover");
    ip    = $urandom;
    lease = $urandom_range(4, 16);
    @(posedge tx_clock);
    dhcp_result <= {1'b1, ip, lease};
    t0 = cycles;
    repeat (2) @(negedge tx_clock);
    check_ip(local_ip, ip, "dhcp offer");
    check_state(network_state_dhcp, network_state_fixedip, 1'b0, 1'b1, "dhcp bound");
    @(posedge tx_clock);
    dhcp_result.success <= 1'b0;     // server goes quiet
    lease_half = int'(lease >> 1);
    expect_pulse((lease_half + 3) * TICKS_PER_SECOND, "renew");
    check_window(cycles - t0, lease_half * TICKS_PER_SECOND, 2 * TICKS_PER_SECOND, "renew");
    check_state(dhcp_rx_enable, network_state_dhcp, 1'b1, 1'b0, "renew request");
    wait_pulse(19 * TICKS_PER_SECOND, waited, seen);   // ack window still open
    check_state(dhcp_rx_enable, seen, 1'b1, 1'b0, "renew ack wait");
    wait_pulse(2 * TICKS_PER_SECOND, waited, seen);    // back in renew_wait after 20 s
    check_state(dhcp_rx_enable, seen, 1'b0, 1'b0, "renew ack timeout");
    wait_pulse(297 * TICKS_PER_SECOND, waited, seen);
    if (seen) begin
      err_timing++;
      $display("renew repeated after %0d cycles, inside the 300 s hold-off", waited);
    end
    expect_pulse(4 * TICKS_PER_SECOND, "renew retry");
    check_state(network_state_dhcp, network_state_fixedip, 1'b0, 1'b1, "renew retry");

    // link loss in renew_ack then in random acquisition states
    for (int n = 0; n < 5; n++) begin
      if (n > 0) begin
        @(posedge tx_clock);
        phy_connected <= 1'b1;
        expect_pulse(int'(SETTLE_CYCLES) + 8, "restart discover");
        repeat ($urandom_range(0, 300)) @(posedge tx_clock);
      end
      @(posedge tx_clock);
      phy_connected <= 1'b0;
      @(posedge tx_clock);
      @(negedge tx_clock);           // one cycle later
      check_state(network_state_dhcp, network_state_fixedip, 1'b1, 1'b1, "link loss");
    end

    // --------------------------------------------------------------------------
    // arbiter grants against the priority model
    // --------------------------------------------------------------------------
    for (int r = 0; r < ARB_ROUNDS; r++) begin
      req       = 4'($urandom_range(1, 15));
      exp_proto = grant_model(req);
      exp_udp   = (exp_proto == dhcp) || (exp_proto == udp);
      @(posedge tx_clock);
      tx_req <= req;
      @(posedge tx_clock);           // grant latched here
      @(negedge tx_clock);
      check_state(tx_start, udp_tx_enable, 1'b0, 1'b0, "before start");
      @(negedge tx_clock);
      check_proto(tx_protocol, exp_proto);
      check_state(tx_start, udp_tx_enable, 1'b1, exp_udp, "start/udp");
      hold = $urandom_range(0, 5);   // phy latency
      repeat (hold) begin
        @(posedge tx_clock);
        tx_req <= 4'($urandom);      // requests move while the grant holds
        @(negedge tx_clock);
        check_proto(tx_protocol, exp_proto);
        check_state(tx_start, udp_tx_enable, 1'b1, exp_udp, "start held");
      end
      @(posedge tx_clock);
      phy_tx_active <= 1'b1;
      tx_req        <= '0;
      @(posedge tx_clock);
      @(negedge tx_clock);
      check_state(tx_start, udp_tx_enable, 1'b0, 1'b0, "release");
      @(posedge tx_clock);
      phy_tx_active <= 1'b0;
    end

    $display("errors: ip %0d state %0d proto %0d timing %0d", err_ip, err_state, err_proto,
             err_timing);
    if ((err_ip + err_state + err_proto + err_timing) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
